// ==== design/backEndPacketSplit.sv ====
`timescale 1ns/100ps
`default_nettype none

module backEndPacketSplit (
  input  dispatchPktPkg::renamedGrpT maskedGrp_i,  // Branch masks already updated
  output dispatchPktPkg::iqGrpT      iqGrp_o,
  output dispatchPktPkg::alGrpT      alGrp_o,
  output dispatchPktPkg::lsqGrpT     lsqGrp_o
);

  dispatchPktPkg::renamedPktT inst;

  always_comb begin
    for (int i = 0; i < dispatchCfgPkg::DISPATCH_WIDTH; i++) begin
      inst = maskedGrp_i[i];

      // Issue queue gets everything the scheduler and execute need
      iqGrp_o[i].pc         = inst.pc;
      iqGrp_o[i].opcode     = inst.opcode;
      iqGrp_o[i].phyDest    = inst.phyDest;
      iqGrp_o[i].phySrc1    = inst.phySrc1;
      iqGrp_o[i].phySrc2    = inst.phySrc2;
      iqGrp_o[i].isLoad     = inst.isLoad;
      iqGrp_o[i].isStore    = inst.isStore;
      iqGrp_o[i].branchMask = inst.branchMask;
      iqGrp_o[i].ctrlId     = inst.ctrlId;

      // Active list keeps what retirement needs to commit the mapping
      alGrp_o[i].isLoad  = inst.isLoad;
      alGrp_o[i].isStore = inst.isStore;
      alGrp_o[i].pc      = inst.pc;
      alGrp_o[i].logDest = inst.logDest;
      alGrp_o[i].phyDest = inst.phyDest;

      lsqGrp_o[i].branchMask = inst.branchMask;  // Lets the LSQ squash on mispredict
      lsqGrp_o[i].isStore    = inst.isStore;
      lsqGrp_o[i].isLoad     = inst.isLoad;
    end
  end

endmodule

`default_nettype wire

// ==== design/backEndSpaceCheck.sv ====
`timescale 1ns/100ps
`default_nettype none

module backEndSpaceCheck (
  input  wire                        clk,
  input  wire                        rstN_i,
  input  dispatchPktPkg::renamedGrpT renamedGrp_i,
  input  dispatchPktPkg::queueOccT   queueOcc_i,
  input  wire                        renameReady_i,   // Rename holds a full group
  input  wire                        flagRecoverEX_i, // Misprediction recovery in progress
  output logic                       backEndReady_o,
  output logic                       stallFrontEnd_o,
  output logic                       dispatchValid_o  // Group sits in the back-end register
);

  logic [dispatchCfgPkg::LDST_CNT_W-1:0] loadCnt;
  logic [dispatchCfgPkg::LDST_CNT_W-1:0] storeCnt;
  logic [dispatchCfgPkg::LSQ_CNT_W:0]    loadSum;
  logic [dispatchCfgPkg::LSQ_CNT_W:0]    storeSum;
  logic [dispatchCfgPkg::IQ_CNT_W:0]     iqSum;
  logic [dispatchCfgPkg::AL_CNT_W:0]     alSum;
  logic                                  stall;

  always_comb begin
    loadCnt  = '0;
    storeCnt = '0;
    for (int i = 0; i < dispatchCfgPkg::DISPATCH_WIDTH; i++) begin
      loadCnt  = loadCnt + (dispatchCfgPkg::LDST_CNT_W)'(renamedGrp_i[i].isLoad);
      storeCnt = storeCnt + (dispatchCfgPkg::LDST_CNT_W)'(renamedGrp_i[i].isStore);
    end
  end

  // One extra bit so the sums cannot wrap
  assign loadSum  = queueOcc_i.loadQueueCnt + loadCnt;
  assign storeSum = queueOcc_i.storeQueueCnt + storeCnt;
  assign iqSum    = queueOcc_i.issueQueueCnt +
                    (dispatchCfgPkg::IQ_CNT_W + 1)'(dispatchCfgPkg::DISPATCH_WIDTH);
  assign alSum    = queueOcc_i.activeListCnt +
                    (dispatchCfgPkg::AL_CNT_W + 1)'(dispatchCfgPkg::DISPATCH_WIDTH);

  // Filling a queue exactly to capacity is allowed
  assign stall = (loadSum > (dispatchCfgPkg::LSQ_CNT_W + 1)'(dispatchCfgPkg::SIZE_LSQ)) |
                 (storeSum > (dispatchCfgPkg::LSQ_CNT_W + 1)'(dispatchCfgPkg::SIZE_LSQ)) |
                 (iqSum > (dispatchCfgPkg::IQ_CNT_W + 1)'(dispatchCfgPkg::SIZE_ISSUEQ)) |
                 (alSum > (dispatchCfgPkg::AL_CNT_W + 1)'(dispatchCfgPkg::SIZE_ACTIVELIST));

  assign stallFrontEnd_o = stall;
  assign backEndReady_o  = ~stall & renameReady_i & ~flagRecoverEX_i;

  always_ff @(posedge clk) begin
    if (!rstN_i) begin
      dispatchValid_o <= 1'b0;
    end else begin
      dispatchValid_o <= backEndReady_o;  // Follows the packet load one cycle later
    end
  end

endmodule

`default_nettype wire

// ==== design/branchMaskUpdate.sv ====
`timescale 1ns/100ps
`default_nettype none

module branchMaskUpdate (
  input  dispatchPktPkg::renamedGrpT renamedGrp_i,
  input  dispatchPktPkg::ctrlVerifyT ctrlVerify_i,
  output dispatchPktPkg::renamedGrpT maskedGrp_o,
  output dispatchPktPkg::maskGrpT    updatedBranchMask_o  // Back to the rename/dispatch register
);

  dispatchPktPkg::branchMaskT clearBit;

  // One-hot position of the checkpoint that just resolved
  always_comb begin
    clearBit = '0;
    if (ctrlVerify_i.verified) begin
      clearBit[ctrlVerify_i.ctrlId] = 1'b1;
    end
  end

  always_comb begin
    for (int i = 0; i < dispatchCfgPkg::DISPATCH_WIDTH; i++) begin
      maskedGrp_o[i]            = renamedGrp_i[i];
      maskedGrp_o[i].branchMask = renamedGrp_i[i].branchMask & ~clearBit;
      updatedBranchMask_o[i]    = maskedGrp_o[i].branchMask;
    end
  end

endmodule

`default_nettype wire

// ==== design/dispatch.sv ====
`timescale 1ns/100ps
`default_nettype none

module dispatch (
  input  wire                        clk,
  input  wire                        rstN_i,
  input  wire                        renameReady_i,
  input  wire                        flagRecoverEX_i,
  input  dispatchPktPkg::ctrlVerifyT ctrlVerify_i,
  input  dispatchPktPkg::queueOccT   queueOcc_i,
  input  dispatchPktPkg::renamedGrpT renamedGrp_i,
  output dispatchPktPkg::iqGrpT      iqGrp_o,
  output dispatchPktPkg::alGrpT      alGrp_o,
  output dispatchPktPkg::lsqGrpT     lsqGrp_o,
  output logic                       dispatchValid_o,
  output dispatchPktPkg::maskGrpT    updatedBranchMask_o,
  output logic                       backEndReady_o,
  output logic                       stallFrontEnd_o
);

  dispatchPktPkg::renamedGrpT maskedGrp;
  dispatchPktPkg::iqGrpT      iqGrp;
  dispatchPktPkg::alGrpT      alGrp;
  dispatchPktPkg::lsqGrpT     lsqGrp;

  branchMaskUpdate maskUpdate (
    .renamedGrp_i        (renamedGrp_i),
    .ctrlVerify_i        (ctrlVerify_i),
    .maskedGrp_o         (maskedGrp),
    .updatedBranchMask_o (updatedBranchMask_o)
  );

  backEndPacketSplit packetSplit (
    .maskedGrp_i (maskedGrp),
    .iqGrp_o     (iqGrp),
    .alGrp_o     (alGrp),
    .lsqGrp_o    (lsqGrp)
  );

  backEndSpaceCheck spaceCheck (
    .clk             (clk),
    .rstN_i          (rstN_i),
    .renamedGrp_i    (renamedGrp_i),
    .queueOcc_i      (queueOcc_i),
    .renameReady_i   (renameReady_i),
    .flagRecoverEX_i (flagRecoverEX_i),
    .backEndReady_o  (backEndReady_o),
    .stallFrontEnd_o (stallFrontEnd_o),
    .dispatchValid_o (dispatchValid_o)
  );

  // Back-end pipeline register, loaded whenever the group is accepted
  dispatchLatch #(.payloadT(dispatchPktPkg::iqGrpT)) iqLatch (
    .clk       (clk),
    .rstN_i    (rstN_i),
    .load_i    (backEndReady_o),
    .payload_i (iqGrp),
    .payload_o (iqGrp_o)
  );

  dispatchLatch #(.payloadT(dispatchPktPkg::alGrpT)) alLatch (
    .clk       (clk),
    .rstN_i    (rstN_i),
    .load_i    (backEndReady_o),
    .payload_i (alGrp),
    .payload_o (alGrp_o)
  );

  dispatchLatch #(.payloadT(dispatchPktPkg::lsqGrpT)) lsqLatch (
    .clk       (clk),
    .rstN_i    (rstN_i),
    .load_i    (backEndReady_o),
    .payload_i (lsqGrp),
    .payload_o (lsqGrp_o)
  );

endmodule

`default_nettype wire

// ==== design/dispatchCfgPkg.sv ====
`default_nettype none

package dispatchCfgPkg;

  // Machine width
  localparam int DISPATCH_WIDTH = 4;        // Lanes per dispatch group

  // Branch checkpoints
  localparam int CHECKPOINTS     = 8;       // Branch mask width
  localparam int CHECKPOINTS_LOG = 3;       // Checkpoint id width

  // Instruction fields
  localparam int SIZE_PC           = 16;
  localparam int SIZE_OPCODE       = 8;
  localparam int SIZE_LOG_REG      = 5;     // Architectural register index
  localparam int SIZE_PHYSICAL_LOG = 7;     // Physical register tag

  // Back-end capacities
  localparam int SIZE_LSQ        = 16;      // Each of load and store queue
  localparam int SIZE_ISSUEQ     = 32;
  localparam int SIZE_ACTIVELIST = 64;

  // Occupancy counters hold 0 up to the full capacity
  localparam int LSQ_CNT_W = 5;
  localparam int IQ_CNT_W  = 6;
  localparam int AL_CNT_W  = 7;

  // Loads or stores in one group, 0 to DISPATCH_WIDTH
  localparam int LDST_CNT_W = 3;

endpackage

`default_nettype wire

// ==== design/dispatchLatch.sv ====
`timescale 1ns/100ps
`default_nettype none

module dispatchLatch #(
  parameter type payloadT = dispatchPktPkg::iqGrpT
) (
  input  wire     clk,
  input  wire     rstN_i,
  input  wire     load_i,     // Group accepted by the back end
  input  payloadT payload_i,
  output payloadT payload_o
);

  always_ff @(posedge clk) begin
    if (!rstN_i) begin
      payload_o <= '0;
    end else if (load_i) begin
      payload_o <= payload_i;
    end
  end

endmodule

`default_nettype wire

// ==== design/dispatchPktPkg.sv ====
`default_nettype none

package dispatchPktPkg;

  typedef logic [dispatchCfgPkg::CHECKPOINTS-1:0] branchMaskT;

  // Instruction as it leaves rename
  typedef struct packed {
    logic [dispatchCfgPkg::SIZE_PC-1:0]           pc;
    logic [dispatchCfgPkg::SIZE_OPCODE-1:0]       opcode;
    logic [dispatchCfgPkg::SIZE_LOG_REG-1:0]      logDest;
    logic [dispatchCfgPkg::SIZE_PHYSICAL_LOG-1:0] phyDest;
    logic [dispatchCfgPkg::SIZE_PHYSICAL_LOG-1:0] phySrc1;
    logic [dispatchCfgPkg::SIZE_PHYSICAL_LOG-1:0] phySrc2;
    logic                                         isLoad;
    logic                                         isStore;
    branchMaskT                                   branchMask;
    logic [dispatchCfgPkg::CHECKPOINTS_LOG-1:0]   ctrlId;   // Checkpoint owned by a branch
  } renamedPktT;

  // Issue queue entry, no architectural destination
  typedef struct packed {
    logic [dispatchCfgPkg::SIZE_PC-1:0]           pc;
    logic [dispatchCfgPkg::SIZE_OPCODE-1:0]       opcode;
    logic [dispatchCfgPkg::SIZE_PHYSICAL_LOG-1:0] phyDest;
    logic [dispatchCfgPkg::SIZE_PHYSICAL_LOG-1:0] phySrc1;
    logic [dispatchCfgPkg::SIZE_PHYSICAL_LOG-1:0] phySrc2;
    logic                                         isLoad;
    logic                                         isStore;
    branchMaskT                                   branchMask;
    logic [dispatchCfgPkg::CHECKPOINTS_LOG-1:0]   ctrlId;
  } iqPktT;

  typedef struct packed {
    logic                                         isLoad;
    logic                                         isStore;
    logic [dispatchCfgPkg::SIZE_PC-1:0]           pc;
    logic [dispatchCfgPkg::SIZE_LOG_REG-1:0]      logDest;
    logic [dispatchCfgPkg::SIZE_PHYSICAL_LOG-1:0] phyDest;
  } alPktT;

  typedef struct packed {
    branchMaskT branchMask;
    logic       isStore;
    logic       isLoad;
  } lsqPktT;

  typedef struct packed {
    logic [dispatchCfgPkg::LSQ_CNT_W-1:0] loadQueueCnt;
    logic [dispatchCfgPkg::LSQ_CNT_W-1:0] storeQueueCnt;
    logic [dispatchCfgPkg::IQ_CNT_W-1:0]  issueQueueCnt;
    logic [dispatchCfgPkg::AL_CNT_W-1:0]  activeListCnt;
  } queueOccT;

  typedef struct packed {
    logic                                       verified;  // Branch resolved correctly
    logic [dispatchCfgPkg::CHECKPOINTS_LOG-1:0] ctrlId;
  } ctrlVerifyT;

  // One entry per dispatch lane
  typedef renamedPktT [dispatchCfgPkg::DISPATCH_WIDTH-1:0] renamedGrpT;
  typedef iqPktT      [dispatchCfgPkg::DISPATCH_WIDTH-1:0] iqGrpT;
  typedef alPktT      [dispatchCfgPkg::DISPATCH_WIDTH-1:0] alGrpT;
  typedef lsqPktT     [dispatchCfgPkg::DISPATCH_WIDTH-1:0] lsqGrpT;
  typedef branchMaskT [dispatchCfgPkg::DISPATCH_WIDTH-1:0] maskGrpT;

endpackage

`default_nettype wire

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the dispatch testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module dispatchTb -f vlog.f \
    -Mdir obj_dir -o simDispatch &&
  ./obj_dir/simDispatch | tee sim.log &&
  grep -q "TESTBENCH PASSED" sim.log &&
  echo "Simulation run succeeded" ||
  { echo "Simulation run did not succeed"; exit 1; }

// ==== sim/dispatchStim.txt ====
// ldq stq iq al renameReady recoverEX verify ctrlId loadMask storeMask expReady expStall
// All values hex; bit i of loadMask and storeMask sets the flag of lane i
00 00 00 00 1 0 0 0 0 0 1 0  // Empty queues
0C 00 00 00 1 0 1 3 F 0 1 0  // Four loads fill the load queue exactly
0D 00 00 00 1 0 0 0 F 0 0 1  // Four loads, one over
0E 00 00 00 1 0 1 7 5 0 1 0  // Two loads in lanes 0 and 2
0F 00 00 00 1 0 0 0 3 0 0 1  // Two loads, one over
0F 00 00 00 1 0 1 0 8 0 1 0  // One load in lane 3 to capacity
10 00 00 00 1 0 0 0 0 0 1 0  // Full load queue, no loads
00 0C 00 00 1 0 1 5 0 F 1 0  // Four stores fill the store queue exactly
00 0D 00 00 1 0 0 0 0 F 0 1  // Four stores, one over
00 0E 00 00 1 0 1 1 0 6 1 0  // Stores in lanes 1 and 2
00 0F 00 00 1 0 0 0 0 9 0 1  // Stores in lanes 0 and 3, one over
00 00 1C 00 1 0 1 2 0 0 1 0  // Issue queue exactly full
00 00 1D 00 1 0 0 0 0 0 0 1  // Issue queue one over
00 00 00 3C 1 0 1 6 0 0 1 0  // Active list exactly full
00 00 00 3D 1 0 0 0 0 0 0 1  // Active list one over
00 00 00 00 0 0 1 4 3 C 0 0  // Rename not ready
00 00 00 00 1 1 0 0 5 A 0 0  // Recovery in progress
00 00 00 00 0 1 1 2 1 2 0 0  // Both blockers at once
0E 0E 1C 3C 1 0 1 0 3 3 1 0  // Every queue at its limit
0E 0E 1C 3C 1 0 0 0 7 3 0 1  // Three loads tip the load queue
00 00 00 00 1 0 1 7 A 5 1 0  // Mixed loads and stores
0D 0D 1D 3D 1 0 1 1 0 0 0 1  // Queues over but no loads or stores
00 00 00 00 1 0 1 4 F F 1 0  // Every lane both load and store

// ==== sim/dispatchTb.sv ====
`timescale 1ns/100ps
`default_nettype none

module dispatchTb;

  localparam int FIELDS        = 12;  // Columns per stimulus row
  localparam int MAX_ROWS      = 64;
  localparam int VALID_TIMEOUT = 8;   // Cycles allowed for dispatchValid_o to rise
  localparam int LANES         = dispatchCfgPkg::DISPATCH_WIDTH;

  logic                       clk;
  logic                       rstN_i;
  logic                       renameReady_i;
  logic                       flagRecoverEX_i;
  dispatchPktPkg::ctrlVerifyT ctrlVerify_i;
  dispatchPktPkg::queueOccT   queueOcc_i;
  dispatchPktPkg::renamedGrpT renamedGrp_i;
  dispatchPktPkg::iqGrpT      iqGrp_o;
  dispatchPktPkg::alGrpT      alGrp_o;
  dispatchPktPkg::lsqGrpT     lsqGrp_o;
  logic                       dispatchValid_o;
  dispatchPktPkg::maskGrpT    updatedBranchMask_o;
  logic                       backEndReady_o;
  logic                       stallFrontEnd_o;

  logic [7:0] stimMem [0:FIELDS*MAX_ROWS-1];

  dispatchPktPkg::iqGrpT   expIq;     // Group last accepted by the back end
  dispatchPktPkg::alGrpT   expAl;
  dispatchPktPkg::lsqGrpT  expLsq;
  dispatchPktPkg::iqGrpT   pendIq;    // Group driven in the current row
  dispatchPktPkg::alGrpT   pendAl;
  dispatchPktPkg::lsqGrpT  pendLsq;
  dispatchPktPkg::maskGrpT pendMask;

  int errCnt;
  int timeoutCnt;

  dispatch UUT (
    .clk                 (clk),
    .rstN_i              (rstN_i),
    .renameReady_i       (renameReady_i),
    .flagRecoverEX_i     (flagRecoverEX_i),
    .ctrlVerify_i        (ctrlVerify_i),
    .queueOcc_i          (queueOcc_i),
    .renamedGrp_i        (renamedGrp_i),
    .iqGrp_o             (iqGrp_o),
    .alGrp_o             (alGrp_o),
    .lsqGrp_o            (lsqGrp_o),
    .dispatchValid_o     (dispatchValid_o),
    .updatedBranchMask_o (updatedBranchMask_o),
    .backEndReady_o      (backEndReady_o),
    .stallFrontEnd_o     (stallFrontEnd_o)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  task automatic checkIq(input string what, input dispatchPktPkg::iqPktT got,
                         input dispatchPktPkg::iqPktT exp);
    if (got !== exp) begin
      $display("Mismatch at %0t ns: %s got %h, expected %h", $time, what, got, exp);
      errCnt++;
    end
  endtask

  task automatic checkAl(input string what, input dispatchPktPkg::alPktT got,
                         input dispatchPktPkg::alPktT exp);
    if (got !== exp) begin
      $display("Mismatch at %0t ns: %s got %h, expected %h", $time, what, got, exp);
      errCnt++;
    end
  endtask

  task automatic checkLsq(input string what, input dispatchPktPkg::lsqPktT got,
                          input dispatchPktPkg::lsqPktT exp);
    if (got !== exp) begin
      $display("Mismatch at %0t ns: %s got %h, expected %h", $time, what, got, exp);
      errCnt++;
    end
  endtask

  task automatic checkMask(input string what, input dispatchPktPkg::branchMaskT got,
                           input dispatchPktPkg::branchMaskT exp);
    if (got !== exp) begin
      $display("Mismatch at %0t ns: %s got %h, expected %h", $time, what, got, exp);
      errCnt++;
    end
  endtask

  task automatic checkBit(input string what, input logic got, input logic exp);
    if (got !== exp) begin
      $display("Mismatch at %0t ns: %s got %b, expected %b", $time, what, got, exp);
      errCnt++;
    end
  endtask

  // Registered packets against the last accepted group
  task automatic checkGroup(input string tag);
    for (int i = 0; i < LANES; i++) begin
      checkIq($sformatf("%s iqGrp_o[%0d]", tag, i), iqGrp_o[i], expIq[i]);
      checkAl($sformatf("%s alGrp_o[%0d]", tag, i), alGrp_o[i], expAl[i]);
      checkLsq($sformatf("%s lsqGrp_o[%0d]", tag, i), lsqGrp_o[i], expLsq[i]);
    end
  endtask

  // Drives one file row with a random payload and works out its packets
  task automatic driveRow(input int base);
    dispatchPktPkg::renamedGrpT grp;
    dispatchPktPkg::ctrlVerifyT vfy;
    dispatchPktPkg::queueOccT   occ;
    logic [LANES-1:0]           ldMask;
    logic [LANES-1:0]           stMask;
    logic [31:0]                rnd;
    occ.loadQueueCnt  = stimMem[base][dispatchCfgPkg::LSQ_CNT_W-1:0];
    occ.storeQueueCnt = stimMem[base+1][dispatchCfgPkg::LSQ_CNT_W-1:0];
    occ.issueQueueCnt = stimMem[base+2][dispatchCfgPkg::IQ_CNT_W-1:0];
    occ.activeListCnt = stimMem[base+3][dispatchCfgPkg::AL_CNT_W-1:0];
    vfy.verified      = stimMem[base+6][0];
    vfy.ctrlId        = stimMem[base+7][dispatchCfgPkg::CHECKPOINTS_LOG-1:0];
    ldMask            = stimMem[base+8][LANES-1:0];
    stMask            = stimMem[base+9][LANES-1:0];
    for (int i = 0; i < LANES; i++) begin
      rnd = $urandom;
      grp[i].pc = rnd[dispatchCfgPkg::SIZE_PC-1:0];
      grp[i].opcode = rnd[31:32-dispatchCfgPkg::SIZE_OPCODE];
      rnd = $urandom;
      grp[i].logDest = rnd[dispatchCfgPkg::SIZE_LOG_REG-1:0];
      grp[i].phyDest = rnd[15:16-dispatchCfgPkg::SIZE_PHYSICAL_LOG];
      grp[i].phySrc1 = rnd[31:32-dispatchCfgPkg::SIZE_PHYSICAL_LOG];
      rnd = $urandom;
      grp[i].phySrc2 = rnd[dispatchCfgPkg::SIZE_PHYSICAL_LOG-1:0];
      grp[i].branchMask = rnd[15:16-dispatchCfgPkg::CHECKPOINTS];
      grp[i].ctrlId = rnd[31:32-dispatchCfgPkg::CHECKPOINTS_LOG];
      grp[i].isLoad = ldMask[i];
      grp[i].isStore = stMask[i];
      pendMask[i] = grp[i].branchMask;
      if (vfy.verified) begin
        pendMask[i][vfy.ctrlId] = 1'b0;  // Resolved checkpoint leaves every mask
      end
      pendIq[i] = {grp[i].pc, grp[i].opcode, grp[i].phyDest, grp[i].phySrc1,
                   grp[i].phySrc2, grp[i].isLoad, grp[i].isStore, pendMask[i], grp[i].ctrlId};
      pendAl[i] = {grp[i].isLoad, grp[i].isStore, grp[i].pc, grp[i].logDest, grp[i].phyDest};
      pendLsq[i] = {pendMask[i], grp[i].isStore, grp[i].isLoad};
    end
    renameReady_i   <= stimMem[base+4][0];
    flagRecoverEX_i <= stimMem[base+5][0];
    ctrlVerify_i    <= vfy;
    queueOcc_i      <= occ;
    renamedGrp_i    <= grp;
  endtask

  initial begin
    int base;
    int waited;
    errCnt          = 0;
    timeoutCnt      = 0;
    void'($urandom(32'hfbc9d739));
    rstN_i          = 1'b0;
    renameReady_i   = 1'b0;
    flagRecoverEX_i = 1'b0;
    ctrlVerify_i    = '0;
    queueOcc_i      = '0;
    renamedGrp_i    = '0;
    expIq           = '0;
    expAl           = '0;
    expLsq          = '0;
    for (int k = 0; k < FIELDS*MAX_ROWS; k++) begin
      stimMem[k] = 8'hff;  // Marks rows past the end of the file
    end
    $readmemh("sim/dispatchStim.txt", stimMem);

    repeat (10) @(posedge clk);
    rstN_i <= 1'b1;
    #1;
    checkBit("reset dispatchValid_o", dispatchValid_o, 1'b0);
    checkGroup("reset");

    base = 0;
    while (base < FIELDS*MAX_ROWS && stimMem[base] != 8'hff) begin
      @(posedge clk);
      driveRow(base);
      #1;  // Combinational outputs settle mid-cycle
      // The cycle before every row has rename held off
      checkBit("dispatchValid_o after idle cycle", dispatchValid_o, 1'b0);
      checkBit("backEndReady_o", backEndReady_o, stimMem[base+10][0]);
      checkBit("stallFrontEnd_o", stallFrontEnd_o, stimMem[base+11][0]);
      for (int i = 0; i < LANES; i++) begin
        checkMask($sformatf("updatedBranchMask_o[%0d]", i), updatedBranchMask_o[i],
                  pendMask[i]);
      end
      if (stimMem[base+10][0]) begin
        waited = 0;
        do begin
          @(posedge clk);
          renameReady_i <= 1'b0;
          #1;
          waited++;
        end while (!dispatchValid_o && waited < VALID_TIMEOUT);
        if (!dispatchValid_o) begin
          $display("Timeout: dispatchValid_o did not rise within %0d cycles", VALID_TIMEOUT);
          timeoutCnt++;
        end else if (waited != 1) begin
          $display("Mismatch at %0t ns: dispatchValid_o rose after %0d cycles, expected 1",
                   $time, waited);
          errCnt++;
        end
        expIq  = pendIq;
        expAl  = pendAl;
        expLsq = pendLsq;
        checkGroup("accepted");
      end else begin
        @(posedge clk);
        renameReady_i <= 1'b0;
        #1;
        checkBit("dispatchValid_o after no dispatch", dispatchValid_o, 1'b0);
        checkGroup("held");
      end
      base += FIELDS;
    end

    $display("Run complete: %0d mismatches, %0d timeouts", errCnt, timeoutCnt);
    if (errCnt == 0 && timeoutCnt == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== vlog.f ====
design/dispatchCfgPkg.sv
design/dispatchPktPkg.sv
design/backEndSpaceCheck.sv
design/branchMaskUpdate.sv
design/backEndPacketSplit.sv
design/dispatchLatch.sv
design/dispatch.sv
sim/dispatchTb.sv
